/* src/edge_pkg.sv */
package edge_pkg;

	// bits per colour channel and per grey sample
	localparam int unsigned PIX_W = 8;

	// width of the reported frame clock count
	localparam int unsigned CYC_W = 24;

	// centre weight of both sobel kernels
	localparam int unsigned KERNEL_MID = 2;

	typedef logic [PIX_W-1:0] pix_t;

	// gradient magnitude clips here
	localparam pix_t MAG_MAX = 8'd255;

	typedef struct packed {
		pix_t r;
		pix_t g;
		pix_t b;
	} rgb_t;

	// valid-only video beats, no ready
	typedef struct packed {
		logic valid;
		rgb_t rgb;
	} pix_in_t;

	typedef struct packed {
		logic valid;
		rgb_t rgb;
	} pix_out_t;

	// one vertical slice of the 3x3 window
	typedef struct packed {
		pix_t top;
		pix_t mid;
		pix_t bot;
	} column_t;

	typedef struct packed {
		column_t left;
		column_t centre;
		column_t right;
	} window_t;

	typedef struct packed {
		logic valid;
		pix_t pix;
	} grey_beat_t;

	typedef struct packed {
		logic    valid;
		window_t win;
	} win_beat_t;

endpackage

/* src/grey_convert.sv */
module grey_convert (
	input  logic                 clk,
	input  logic                 rst_n,
	input  edge_pkg::pix_in_t    pix_in,
	output edge_pkg::grey_beat_t grey
);

	// r + 2g + b peaks at 1020
	logic [9:0]     luma_sum;
	logic           grey_valid;
	edge_pkg::pix_t grey_pix;

	assign luma_sum = 10'(pix_in.rgb.r) + {1'b0, pix_in.rgb.g, 1'b0} + 10'(pix_in.rgb.b);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			grey_valid <= 1'b0;
		end else begin
			grey_valid <= pix_in.valid;
		end
	end

	// divide by four, drop the fraction
	always_ff @(posedge clk) begin
		if (pix_in.valid) begin
			grey_pix <= luma_sum[9:2];
		end
	end

	assign grey = '{valid: grey_valid, pix: grey_pix};

endmodule

/* src/stream_delay.sv */
module stream_delay #(
	parameter type         T     = edge_pkg::pix_in_t,
	parameter int unsigned DEPTH = 2
) (
	input  logic clk,
	input  logic rst_n,
	input  T     d,
	output T     q
);

	// payload stages, valid field rebuilt from vld
	T           pipe [DEPTH];
	logic [DEPTH-1:0] vld;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			vld <= '0;
		end else begin
			vld[0] <= d.valid;
			for (int i = 1; i < DEPTH; i++) begin
				vld[i] <= vld[i-1];
			end
		end
	end

	// shifts every clock so gaps keep their spacing
	always_ff @(posedge clk) begin
		pipe[0] <= d;
		for (int i = 1; i < DEPTH; i++) begin
			pipe[i] <= pipe[i-1];
		end
	end

	always_comb begin
		q       = pipe[DEPTH-1];
		q.valid = vld[DEPTH-1];
	end

endmodule

/* src/line_buffer.sv */
module line_buffer #(
	parameter int unsigned IMG_COLS = 640
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  edge_pkg::grey_beat_t grey,
	output edge_pkg::column_t    col,
	output logic                 col_valid
);

	localparam int unsigned COL_W = (IMG_COLS > 1) ? $clog2(IMG_COLS) : 1;

	// two rows of grey pixels
	// old_sel points at the row written longest ago
	edge_pkg::pix_t   row_mem [2][IMG_COLS];
	logic [COL_W-1:0] wr_col;
	logic             old_sel;
	logic             row_end;

	assign row_end = (wr_col == COL_W'(IMG_COLS - 1));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_col    <= '0;
			old_sel   <= 1'b0;
			col_valid <= 1'b0;
			for (int r = 0; r < 2; r++) begin
				for (int c = 0; c < IMG_COLS; c++) begin
					row_mem[r][c] <= '0;
				end
			end
		end else begin
			col_valid <= grey.valid;
			if (grey.valid) begin
				// new pixel replaces the older row in place
				row_mem[old_sel][wr_col] <= grey.pix;
				if (row_end) begin
					wr_col  <= '0;
					// row just written becomes the newer one
					old_sel <= ~old_sel;
				end else begin
					wr_col <= wr_col + 1'b1;
				end
			end
		end
	end

	// both rows read before this beat's write lands
	// top two rows back, mid one row back, bot the new pixel
	always_ff @(posedge clk) begin
		if (grey.valid) begin
			col.top <= row_mem[old_sel][wr_col];
			col.mid <= row_mem[~old_sel][wr_col];
			col.bot <= grey.pix;
		end
	end

	// write column must index inside the row memories
	assert property (@(posedge clk) disable iff (!rst_n)
		wr_col < IMG_COLS)
		else $error("line_buffer column counter out of range");

endmodule

/* src/window_gen.sv */
module window_gen #(
	parameter int unsigned IMG_COLS = 640,
	parameter int unsigned IMG_ROWS = 480
) (
	input  logic                clk,
	input  logic                rst_n,
	input  edge_pkg::column_t   col,
	input  logic                col_valid,
	output edge_pkg::win_beat_t win
);

	localparam int unsigned COL_W  = (IMG_COLS > 1) ? $clog2(IMG_COLS) : 1;
	localparam int unsigned ROW_W  = (IMG_ROWS > 1) ? $clog2(IMG_ROWS) : 1;
	localparam int unsigned FILL_N = IMG_COLS + 1;
	localparam int unsigned FILL_W = $clog2(IMG_COLS + 2);

	// prev0 newest stored slice, prev1 the one before
	edge_pkg::column_t prev0;
	edge_pkg::column_t prev1;
	edge_pkg::window_t taps;
	edge_pkg::window_t padded;
	edge_pkg::window_t win_q;
	logic              win_valid;

	// slices seen before the first centre exists
	logic [FILL_W-1:0] fill_cnt;
	logic              primed;

	// centre position, one row and one column behind the input
	logic [COL_W-1:0]  cen_col;
	logic [ROW_W-1:0]  cen_row;

	assign primed = (fill_cnt == FILL_W'(FILL_N));

	always_comb begin
		taps.left   = prev1;
		taps.centre = prev0;
		taps.right  = col;
		padded      = taps;
		// zero padding outside the frame
		if (cen_row == '0) begin
			padded.left.top   = '0;
			padded.centre.top = '0;
			padded.right.top  = '0;
		end
		if (cen_row == ROW_W'(IMG_ROWS - 1)) begin
			padded.left.bot   = '0;
			padded.centre.bot = '0;
			padded.right.bot  = '0;
		end
		// left taps here belong to the previous row
		if (cen_col == '0) begin
			padded.left = '0;
		end
		// right taps here belong to the next row
		if (cen_col == COL_W'(IMG_COLS - 1)) begin
			padded.right = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fill_cnt  <= '0;
			cen_col   <= '0;
			cen_row   <= '0;
			win_valid <= 1'b0;
		end else begin
			win_valid <= col_valid && primed;
			if (col_valid) begin
				if (!primed) begin
					fill_cnt <= fill_cnt + 1'b1;
				end else if (cen_col == COL_W'(IMG_COLS - 1)) begin
					cen_col <= '0;
					// wrap into the next frame
					if (cen_row == ROW_W'(IMG_ROWS - 1)) begin
						cen_row <= '0;
					end else begin
						cen_row <= cen_row + 1'b1;
					end
				end else begin
					cen_col <= cen_col + 1'b1;
				end
			end
		end
	end

	// shift left on each valid slice
	always_ff @(posedge clk) begin
		if (col_valid) begin
			prev0 <= col;
			prev1 <= prev0;
			win_q <= padded;
		end
	end

	assign win = '{valid: win_valid, win: win_q};

endmodule

/* src/sobel_mag.sv */
module sobel_mag (
	input  logic                 clk,
	input  logic                 rst_n,
	input  edge_pkg::win_beat_t  win,
	output edge_pkg::grey_beat_t mag
);

	// weighted three-tap sum
	// outer taps one, middle tap KERNEL_MID, max 1020
	function automatic logic [9:0] wsum(
		input edge_pkg::pix_t a,
		input edge_pkg::pix_t m,
		input edge_pkg::pix_t c
	);
		return 10'(a) + 10'(m) * 10'(edge_pkg::KERNEL_MID) + 10'(c);
	endfunction

	logic [9:0]        sum_r;
	logic [9:0]        sum_l;
	logic [9:0]        sum_b;
	logic [9:0]        sum_t;
	logic signed [10:0] gx_d;
	logic signed [10:0] gy_d;
	logic signed [10:0] gx_q;
	logic signed [10:0] gy_q;
	logic              s1_valid;
	logic [10:0]       abs_x;
	logic [10:0]       abs_y;
	logic [11:0]       mag_sum;
	edge_pkg::pix_t    clipped;
	edge_pkg::pix_t    mag_pix;
	logic              mag_valid;

	// gx right column minus left column
	assign sum_r = wsum(win.win.right.top, win.win.right.mid, win.win.right.bot);
	assign sum_l = wsum(win.win.left.top, win.win.left.mid, win.win.left.bot);
	// gy bottom row minus top row
	assign sum_b = wsum(win.win.left.bot, win.win.centre.bot, win.win.right.bot);
	assign sum_t = wsum(win.win.left.top, win.win.centre.top, win.win.right.top);

	assign gx_d = $signed({1'b0, sum_r}) - $signed({1'b0, sum_l});
	assign gy_d = $signed({1'b0, sum_b}) - $signed({1'b0, sum_t});

	// |g| fits in 10 bits, sum in 11
	assign abs_x   = gx_q[10] ? -gx_q : gx_q;
	assign abs_y   = gy_q[10] ? -gy_q : gy_q;
	assign mag_sum = abs_x + abs_y;
	assign clipped = (mag_sum > 12'(edge_pkg::MAG_MAX)) ? edge_pkg::MAG_MAX : mag_sum[7:0];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s1_valid  <= 1'b0;
			mag_valid <= 1'b0;
		end else begin
			s1_valid  <= win.valid;
			mag_valid <= s1_valid;
		end
	end

	// stage 1 gradients, stage 2 magnitude
	always_ff @(posedge clk) begin
		if (win.valid) begin
			gx_q <= gx_d;
			gy_q <= gy_d;
		end
		if (s1_valid) begin
			mag_pix <= clipped;
		end
	end

	assign mag = '{valid: mag_valid, pix: mag_pix};

endmodule

/* src/frame_timer.sv */
module frame_timer #(
	parameter int unsigned IMG_COLS = 640,
	parameter int unsigned IMG_ROWS = 480
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      in_valid,
	output logic [edge_pkg::CYC_W-1:0] frame_cycles,
	output logic                      frame_done
);

	localparam int unsigned PIX_TOTAL = IMG_COLS * IMG_ROWS;
	localparam int unsigned CNT_W     = (PIX_TOTAL > 1) ? $clog2(PIX_TOTAL) : 1;

	logic [CNT_W-1:0]          pix_cnt;
	logic [edge_pkg::CYC_W-1:0] cyc_cnt;
	logic [edge_pkg::CYC_W-1:0] cyc_now;
	logic                      in_frame;
	logic                      first_pix;
	logic                      last_pix;

	assign first_pix = in_valid && (pix_cnt == '0);
	assign last_pix  = in_valid && (pix_cnt == CNT_W'(PIX_TOTAL - 1));

	// clocks so far including this one
	assign cyc_now = first_pix ? edge_pkg::CYC_W'(1) : cyc_cnt + 1'b1;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pix_cnt      <= '0;
			cyc_cnt      <= '0;
			in_frame     <= 1'b0;
			frame_cycles <= '0;
			frame_done   <= 1'b0;
		end else begin
			frame_done <= last_pix;
			if (in_valid) begin
				pix_cnt <= last_pix ? '0 : pix_cnt + 1'b1;
			end
			// gaps inside a frame still count
			if (first_pix || in_frame) begin
				cyc_cnt <= cyc_now;
			end
			if (first_pix) begin
				in_frame <= 1'b1;
			end
			// last pixel ends the frame, even a one-pixel frame
			if (last_pix) begin
				in_frame     <= 1'b0;
				frame_cycles <= cyc_now;
			end
		end
	end

endmodule

/* src/edge_detect_top.sv */
module edge_detect_top #(
	parameter int unsigned IMG_COLS = 640,
	parameter int unsigned IMG_ROWS = 480
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      edge_en,
	input  edge_pkg::pix_in_t         pix_in,
	output edge_pkg::pix_out_t        pix_out,
	output logic [edge_pkg::CYC_W-1:0] frame_cycles,
	output logic                      frame_done
);

	edge_pkg::grey_beat_t grey;
	edge_pkg::column_t    col;
	logic                 col_valid;
	edge_pkg::win_beat_t  win;
	edge_pkg::grey_beat_t mag;
	edge_pkg::pix_in_t    byp;
	logic                 sel_valid;
	edge_pkg::rgb_t       sel_rgb;
	logic                 out_valid;
	edge_pkg::rgb_t       out_rgb;

	grey_convert u_grey (
		.clk    (clk),
		.rst_n  (rst_n),
		.pix_in (pix_in),
		.grey   (grey)
	);

	line_buffer #(.IMG_COLS(IMG_COLS)) u_lines (
		.clk       (clk),
		.rst_n     (rst_n),
		.grey      (grey),
		.col       (col),
		.col_valid (col_valid)
	);

	window_gen #(.IMG_COLS(IMG_COLS), .IMG_ROWS(IMG_ROWS)) u_window (
		.clk       (clk),
		.rst_n     (rst_n),
		.col       (col),
		.col_valid (col_valid),
		.win       (win)
	);

	sobel_mag u_sobel (
		.clk   (clk),
		.rst_n (rst_n),
		.win   (win),
		.mag   (mag)
	);

	// rgb bypass, two clocks
	stream_delay #(.T(edge_pkg::pix_in_t), .DEPTH(2)) u_bypass (
		.clk   (clk),
		.rst_n (rst_n),
		.d     (pix_in),
		.q     (byp)
	);

	frame_timer #(.IMG_COLS(IMG_COLS), .IMG_ROWS(IMG_ROWS)) u_timer (
		.clk          (clk),
		.rst_n        (rst_n),
		.in_valid     (pix_in.valid),
		.frame_cycles (frame_cycles),
		.frame_done   (frame_done)
	);

	// edge mode puts the magnitude on all three channels
	always_comb begin
		if (edge_en) begin
			sel_valid = mag.valid;
			sel_rgb   = '{r: mag.pix, g: mag.pix, b: mag.pix};
		end else begin
			sel_valid = byp.valid;
			sel_rgb   = byp.rgb;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= sel_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (sel_valid) begin
			out_rgb <= sel_rgb;
		end
	end

	assign pix_out = '{valid: out_valid, rgb: out_rgb};

	// mode only switches under reset
	assert property (@(posedge clk) rst_n && $past(rst_n) |-> $stable(edge_en))
		else $error("edge_en changed outside reset");

	// every bypass output beat had an input beat three clocks before
	assert property (@(posedge clk) disable iff (!rst_n)
		(!edge_en && pix_out.valid) |-> $past(pix_in.valid, 3))
		else $error("bypass output without matching input");

endmodule

/* tb/tb_edge_detect.sv */
module tb_edge_detect;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int IMG_COLS  = 8;
	localparam int IMG_ROWS  = 6;
	localparam int FRAME_PIX = IMG_COLS * IMG_ROWS;
	// frames driven over the whole run with partial frames rounded up
	localparam int NUM_FRAMES   = 17;
	localparam int WATCHDOG_CYC = NUM_FRAMES * FRAME_PIX * 4 + 1000;
	localparam int KIND_RANDOM  = 0;
	localparam int KIND_FLAT    = 1;
	localparam int KIND_CHECKER = 2;

	typedef logic [edge_pkg::CYC_W-1:0] cyc_t;

	logic                clk;
	logic                rst_n;
	logic                edge_en;
	edge_pkg::pix_in_t   pix_in;
	edge_pkg::pix_out_t  pix_out;
	cyc_t                frame_cycles;
	logic                frame_done;

	int                  seed = 32'hc3f16cbd;
	string               test_name = "init";
	logic                edge_mode;
	int                  gap_pct;
	int                  step;
	int                  start_step;
	int                  frame_pos;
	// model frame as rgb in and grey per pixel
	edge_pkg::rgb_t      rgb_frame [FRAME_PIX];
	int                  grey_frame [FRAME_PIX];
	// expected output beats and frame clock counts in order
	edge_pkg::rgb_t      exp_q [$];
	cyc_t                cyc_q [$];
	edge_pkg::rgb_t      exp_rgb;
	cyc_t                exp_cyc;

	edge_detect_top #(.IMG_COLS(IMG_COLS), .IMG_ROWS(IMG_ROWS)) DUT (
		.clk          (clk),
		.rst_n        (rst_n),
		.edge_en      (edge_en),
		.pix_in       (pix_in),
		.pix_out      (pix_out),
		.frame_cycles (frame_cycles),
		.frame_done   (frame_done)
	);

	always #10 clk = ~clk;

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic check_pix(input edge_pkg::rgb_t exp_v, input edge_pkg::rgb_t act_v);
		if (exp_v !== act_v) begin
			fail_run($sformatf("Error: %s pixel expected %h actual %h", test_name, exp_v, act_v));
		end
	endtask

	task automatic check_cycles(input cyc_t exp_v, input cyc_t act_v);
		if (exp_v !== act_v) begin
			fail_run($sformatf("Error: %s frame_cycles expected %0d actual %0d",
				test_name, exp_v, act_v));
		end
	endtask

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic edge_pkg::rgb_t rand_rgb();
		return edge_pkg::rgb_t'(24'($random(seed)));
	endfunction

	// weights 1, 2, 1 on r, g, b then truncate
	function automatic int grey_of(input edge_pkg::rgb_t p);
		return (int'(p.r) + 2 * int'(p.g) + int'(p.b)) / 4;
	endfunction

	// zero outside the frame
	function automatic int tap(input int r, input int c);
		if (r < 0 || r >= IMG_ROWS || c < 0 || c >= IMG_COLS) begin
			return 0;
		end
		return grey_frame[r * IMG_COLS + c];
	endfunction

	function automatic int sobel_at(input int r, input int c);
		int gx;
		int gy;
		int m;
		gx = tap(r - 1, c + 1) + 2 * tap(r, c + 1) + tap(r + 1, c + 1)
			- tap(r - 1, c - 1) - 2 * tap(r, c - 1) - tap(r + 1, c - 1);
		gy = tap(r + 1, c - 1) + 2 * tap(r + 1, c) + tap(r + 1, c + 1)
			- tap(r - 1, c - 1) - 2 * tap(r - 1, c) - tap(r - 1, c + 1);
		m = ((gx < 0) ? -gx : gx) + ((gy < 0) ? -gy : gy);
		return (m > 255) ? 255 : m;
	endfunction

	task automatic build_frame(input int kind);
		edge_pkg::rgb_t flat;
		edge_pkg::pix_t v;
		int             r;
		int             c;
		// bright enough that the borders show an edge
		flat = edge_pkg::rgb_t'(rand_rgb() | 24'h404040);
		for (int i = 0; i < FRAME_PIX; i++) begin
			r = i / IMG_COLS;
			c = i % IMG_COLS;
			if (kind == KIND_FLAT) begin
				rgb_frame[i] = flat;
			end else if (kind == KIND_CHECKER) begin
				// 2x2 squares so interior edges exist
				v = (((r / 2) + (c / 2)) % 2 != 0) ? 8'hff : 8'h00;
				rgb_frame[i] = '{r: v, g: v, b: v};
			end else begin
				rgb_frame[i] = rand_rgb();
			end
			grey_frame[i] = grey_of(rgb_frame[i]);
		end
	endtask

	// magnitude on all three channels
	task automatic push_model();
		edge_pkg::pix_t v;
		for (int i = 0; i < FRAME_PIX; i++) begin
			v = edge_pkg::pix_t'(sobel_at(i / IMG_COLS, i % IMG_COLS));
			exp_q.push_back('{r: v, g: v, b: v});
		end
	endtask

	// one clock of stimulus plus the model's frame clock count
	task automatic drive_beat(input logic valid, input edge_pkg::rgb_t rgb);
		@(negedge clk);
		pix_in = '{valid: valid, rgb: rgb};
		if (valid) begin
			if (!edge_mode) begin
				exp_q.push_back(rgb);
			end
			if (frame_pos == 0) begin
				start_step = step;
			end
			if (frame_pos == FRAME_PIX - 1) begin
				cyc_q.push_back(cyc_t'(step - start_step + 1));
				frame_pos = 0;
			end else begin
				frame_pos++;
			end
		end
		step++;
	endtask

	task automatic drive_frame(input int kind, input int npix);
		int gaps;
		build_frame(kind);
		if (edge_mode) begin
			push_model();
		end
		for (int i = 0; i < npix; i++) begin
			if (rand_below(100) < gap_pct) begin
				gaps = 1 + rand_below(3);
				// junk payload during gaps
				repeat (gaps) drive_beat(1'b0, rand_rgb());
			end
			drive_beat(1'b1, rgb_frame[i]);
		end
	endtask

	// left is what stays stuck behind the window in edge mode
	task automatic wait_drain(input int left);
		drive_beat(1'b0, '0);
		while (exp_q.size() > left || cyc_q.size() != 0) begin
			drive_beat(1'b0, '0);
		end
		repeat (8) drive_beat(1'b0, '0);
		if (exp_q.size() != left) begin
			fail_run($sformatf("%s: output beats kept coming after the input stopped", test_name));
		end
	endtask

	task automatic apply_reset(input logic mode);
		@(negedge clk);
		rst_n     = 1'b0;
		pix_in    = '0;
		edge_en   = mode;
		edge_mode = mode;
		repeat (5) @(negedge clk);
		exp_q.delete();
		cyc_q.delete();
		frame_pos = 0;
		rst_n     = 1'b1;
	endtask

	// registered outputs settle before the falling edge
	always @(negedge clk) begin
		if (pix_out.valid) begin
			if (exp_q.size() == 0) begin
				fail_run($sformatf("%s: output beat with no input pending", test_name));
			end
			exp_rgb = exp_q.pop_front();
			check_pix(exp_rgb, pix_out.rgb);
		end
		if (frame_done) begin
			if (cyc_q.size() == 0) begin
				fail_run($sformatf("%s: frame_done pulsed with no frame completed", test_name));
			end
			exp_cyc = cyc_q.pop_front();
			check_cycles(exp_cyc, frame_cycles);
		end
	end

	initial begin
		repeat (WATCHDOG_CYC) @(posedge clk);
		fail_run("watchdog expired, the output stream stalled");
	end

	initial begin
		clk        = 1'b0;
		rst_n      = 1'b0;
		edge_en    = 1'b0;
		pix_in     = '0;
		edge_mode  = 1'b0;
		gap_pct    = 25;
		step       = 0;
		start_step = 0;
		frame_pos  = 0;

		apply_reset(1'b0);
		test_name = "bypass";
		drive_frame(KIND_RANDOM, FRAME_PIX);
		drive_frame(KIND_RANDOM, FRAME_PIX);
		wait_drain(0);

		// each edge test ends on a flush frame
		apply_reset(1'b1);
		test_name = "flat_edge";
		drive_frame(KIND_FLAT, FRAME_PIX);
		drive_frame(KIND_RANDOM, FRAME_PIX);
		wait_drain(IMG_COLS + 1);

		apply_reset(1'b1);
		test_name = "random_edge";
		repeat (3) drive_frame(KIND_RANDOM, FRAME_PIX);
		drive_frame(KIND_RANDOM, FRAME_PIX);
		wait_drain(IMG_COLS + 1);

		apply_reset(1'b1);
		test_name = "saturation";
		drive_frame(KIND_CHECKER, FRAME_PIX);
		drive_frame(KIND_CHECKER, FRAME_PIX);
		drive_frame(KIND_RANDOM, FRAME_PIX);
		wait_drain(IMG_COLS + 1);

		// long gaps stretch the frame clock count
		apply_reset(1'b0);
		test_name = "frame_timing";
		gap_pct = 60;
		repeat (3) drive_frame(KIND_RANDOM, FRAME_PIX);
		wait_drain(0);

		apply_reset(1'b1);
		test_name = "reset_mid_frame";
		gap_pct = 25;
		drive_frame(KIND_RANDOM, FRAME_PIX / 2);
		apply_reset(1'b1);
		repeat (10) begin
			@(negedge clk);
			if (pix_out.valid || frame_done) begin
				fail_run("output went valid after reset with no new input");
			end
		end
		drive_frame(KIND_RANDOM, FRAME_PIX);
		drive_frame(KIND_RANDOM, FRAME_PIX);
		wait_drain(IMG_COLS + 1);

		$display("Done: no errors");
		$finish;
	end

endmodule

/* tb.f */
src/edge_pkg.sv
src/grey_convert.sv
src/stream_delay.sv
src/line_buffer.sv
src/window_gen.sv
src/sobel_mag.sv
src/frame_timer.sv
src/edge_detect_top.sv
tb/tb_edge_detect.sv

/* Makefile */
# Verilator build of the edge detector testbench

VERILATOR ?= verilator
TOP       ?= tb_edge_detect
BUILD_DIR ?= build
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SRCS := $(filter %.sv %.v,$(shell cat tb.f))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when the file list or a source changes
$(BIN): tb.f $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f tb.f

# status comes from the search for the pass message
run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf $(BUILD_DIR)
